// File: flist.f
dec_pkg.sv
group_fetch_fifo.sv
group_loader.sv
unit_lane.sv
packet_packer.sv
decompressor_top.sv
tb_decompressor.sv

// File: Makefile
TOP             ?= tb_decompressor
SIM_DIR         ?= obj_dir
VERILATOR       ?= verilator
VERILATOR_FLAGS ?= --binary --timing -j 0
FLIST           ?= flist.f
PASS_MSG        := Simulation completed successfully

SIM_BIN := $(SIM_DIR)/V$(TOP)
SOURCES := $(shell cat $(FLIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(SIM_DIR) -f $(FLIST)

# the run fails unless the pass message shows up in the output
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(SIM_DIR)

// File: tb_decompressor.sv
`timescale 1ns/1ps

module tb_decompressor;
    import dec_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int TOTAL_GROUPS = 66;                   // groups handed out over all tests
    localparam int WATCHDOG_NS  = (TOTAL_GROUPS * 200 + 1000) * CLK_PERIOD;

    logic            layer23_gated_clk;
    logic            rst_n;
    logic            start;
    compress_group_t mem_data;
    logic            mem_data_valid;
    logic            mem_ack;
    logic            global_buffer_req;
    logic            mem_req;
    out_packet_t     out_packet;
    logic            map_done;

    integer          seed = 46;
    int              cycle = 0;
    int              errors = 0;
    int              tests_run = 0;
    int              tests_failed = 0;
    compress_group_t map_q[$];                          // groups of the map under test
    logic [7:0]      exp_q[$];                          // bytes the DUT still owes
    int              due_q[$];                          // cycle each requested word comes back
    int              idx_q[$];                          // word index of each request in flight
    int              req_count = 0;
    int              last_due = 0;
    bit              end_sent = 1'b0;                   // end group already returned to the DUT
    bit              bp_mode = 1'b0;
    int              bp_left = 0;
    bit              held_valid = 1'b0;
    out_packet_t     held_pkt;

    decompressor_top #(.FIFO_DEPTH(16)) i_dut (
        .layer23_gated_clk (layer23_gated_clk),
        .rst_n             (rst_n),
        .start             (start),
        .mem_data          (mem_data),
        .mem_data_valid    (mem_data_valid),
        .mem_ack           (mem_ack),
        .global_buffer_req (global_buffer_req),
        .mem_req           (mem_req),
        .out_packet        (out_packet),
        .map_done          (map_done)
    );

    always #(CLK_PERIOD / 2) layer23_gated_clk = ~layer23_gated_clk;
    always @(posedge layer23_gated_clk) cycle <= cycle + 1;

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (expected !== actual) begin
            $display("Error: %s expected %0h got %0h at cycle %0d", name, expected, actual, cycle);
            errors++;
        end
    endtask

    // run_mod of 0 gives a group with no zero runs at all
    function automatic compress_group_t make_group(input logic flag, input logic [2:0] idx,
                                                   input int base, input int run_mod);
        compress_group_t grp;
        grp.end_flag = flag;
        grp.end_idx  = idx;
        for (int u = 0; u < UNITS_PER_GROUP; u++) begin
            grp.units[u].zero_run = 4'(run_mod == 0 ? 0 : (base + 3 * u) % run_mod);
            grp.units[u].val      = 8'(base * 16 + u + 1);
        end
        return grp;
    endfunction

    // builds the expected byte stream of map_q straight from the expansion rule
    function automatic void build_expected();
        compress_group_t grp;
        compress_unit_t  unit;
        bit              all_valid;
        exp_q.delete();
        foreach (map_q[g]) begin
            grp       = map_q[g];
            all_valid = grp.end_idx == 3'b111;
            for (int u = 0; u < UNITS_PER_GROUP; u++) begin
                unit = grp.units[u];
                if (all_valid || u <= int'(grp.end_idx)) begin   // units past the end give nothing
                    repeat (unit.zero_run) exp_q.push_back(8'h00);
                    if (all_valid || u < int'(grp.end_idx) || grp.end_flag) begin
                        exp_q.push_back(unit.val);
                    end
                end
            end
        end
    endfunction

    // the memory model and the global buffer side are both driven on the falling edge
    always @(negedge layer23_gated_clk) begin
        int delay;
        int due;
        if (end_sent) begin
            check("mem_req", 64'(0), 64'(mem_req));       // fetching stops once the end group is in
        end
        mem_data_valid = 1'b0;
        if (due_q.size() != 0 && due_q[0] <= cycle) begin
            // words past the map are filler that the DUT must drop
            mem_data = (idx_q[0] < map_q.size()) ? map_q[idx_q[0]] :
                       make_group(1'b0, 3'b111, 14, 3);
            mem_data_valid = 1'b1;
            if (idx_q[0] == map_q.size() - 1) begin
                end_sent = 1'b1;
            end
            void'(due_q.pop_front());
            void'(idx_q.pop_front());
        end
        mem_ack = mem_req;                                // every request is taken at once
        if (mem_req) begin
            delay = 1 + int'($unsigned($random(seed)) % 6);
            due   = (cycle + delay > last_due) ? cycle + delay : last_due + 1;   // keeps request order
            due_q.push_back(due);
            idx_q.push_back(req_count);
            last_due = due;
            req_count++;
        end
        if (!bp_mode) begin
            global_buffer_req = 1'b1;
        end else if (bp_left > 0) begin
            bp_left--;
        end else begin
            global_buffer_req = !global_buffer_req;      // flip and pick the next span length
            bp_left = global_buffer_req ? int'($unsigned($random(seed)) % 4) :
                                          3 + int'($unsigned($random(seed)) % 18);
        end
    end

    // compares every taken packet against the front of the expected stream
    always @(posedge layer23_gated_clk) begin
        int         n;
        logic [7:0] exp_mask;
        if (!rst_n || start) begin
            held_valid = 1'b0;
        end else begin
            if (held_valid) begin
                check("out_packet.data while refused", held_pkt.data, out_packet.data);
                check("out_packet.valid_mask while refused",
                      64'({held_pkt.valid_mask, held_pkt.packet_valid}),
                      64'({out_packet.valid_mask, out_packet.packet_valid}));
            end
            held_valid = out_packet.packet_valid && !global_buffer_req;
            held_pkt   = out_packet;
            if (out_packet.packet_valid && global_buffer_req) begin
                if (exp_q.size() == 0) begin
                    $display("a packet was taken after the last expected byte of the map");
                    errors++;
                end else begin
                    n        = (exp_q.size() < PACKET_BYTES) ? exp_q.size() : PACKET_BYTES;
                    exp_mask = '0;
                    for (int k = 0; k < n; k++) exp_mask[k] = 1'b1;   // only the last packet is short
                    check("out_packet.valid_mask", 64'(exp_mask), 64'(out_packet.valid_mask));
                    for (int k = 0; k < n; k++) begin
                        check($sformatf("out_packet.data[%0d]", k), 64'(exp_q[0]),
                              64'(out_packet.data[k]));
                        void'(exp_q.pop_front());
                    end
                end
            end
        end
    end

    task automatic make_random_map(input int n_groups, input int max_run);
        compress_group_t grp;
        @(posedge layer23_gated_clk);                   // keeps $random calls off the driving edge
        map_q.delete();
        for (int g = 0; g < n_groups; g++) begin
            for (int u = 0; u < UNITS_PER_GROUP; u++) begin
                grp.units[u].zero_run = 4'($unsigned($random(seed)) % (max_run + 1));
                grp.units[u].val      = 8'($random(seed));
            end
            grp.end_flag = 1'b0;
            grp.end_idx  = 3'b111;
            if (g == n_groups - 1) begin
                grp.end_idx  = 3'($unsigned($random(seed)) % 7);
                grp.end_flag = 1'($random(seed));
            end
            map_q.push_back(grp);
        end
    endtask

    task automatic run_map(input int num, input string name, input bit with_bp);
        int errors_before;
        int n_bytes;
        errors_before = errors;
        while (idx_q.size() != 0) @(negedge layer23_gated_clk);   // late filler of the last map
        build_expected();
        n_bytes = exp_q.size();
        @(negedge layer23_gated_clk);
        bp_mode   = with_bp;
        end_sent  = 1'b0;
        req_count = 0;
        start     = 1'b1;
        @(negedge layer23_gated_clk);
        start = 1'b0;
        check("map_done", 64'(0), 64'(map_done));
        while (!map_done) @(negedge layer23_gated_clk);
        // map_done only follows the last packet of the map
        if (exp_q.size() != 0) begin
            $display("map_done rose with %0d expected bytes never delivered", exp_q.size());
            errors++;
        end
        repeat (12) @(negedge layer23_gated_clk);        // room for a stray packet or request
        check("map_done", 64'(1), 64'(map_done));
        bp_mode = 1'b0;
        tests_run++;
        if (errors != errors_before) tests_failed++;
        $display("test %0d %s: %0d bytes, %s", num, name, n_bytes,
                 (errors == errors_before) ? "passed" : "FAILED");
    endtask

    initial begin
        layer23_gated_clk = 1'b0;
        rst_n             = 1'b0;
        start             = 1'b0;
        mem_data          = '0;
        mem_data_valid    = 1'b0;
        mem_ack           = 1'b0;
        global_buffer_req = 1'b0;
        repeat (8) @(posedge layer23_gated_clk);
        @(negedge layer23_gated_clk);
        rst_n = 1'b1;
        check("mem_req", 64'(0), 64'(mem_req));
        check("out_packet.packet_valid", 64'(0), 64'(out_packet.packet_valid));
        check("map_done", 64'(0), 64'(map_done));

        map_q.delete();
        map_q.push_back(make_group(1'b1, 3'd4, 1, 0));   // five bytes, mask 0x1f
        run_map(1, "single end group", 1'b0);

        for (int f = 0; f < 2; f++) begin
            map_q.delete();
            map_q.push_back(make_group(1'b0, 3'b111, 2, 7));
            map_q.push_back(make_group(1'b0, 3'b111, 3, 5));
            map_q.push_back(make_group(1'(f), 3'd2, 4, 6));
            run_map(2, f ? "end index 2 flag set" : "end index 2 flag clear", 1'b0);
        end

        make_random_map(30, 15);
        run_map(3, "long random map", 1'b0);
        make_random_map(20, 3);
        run_map(4, "back-pressure", 1'b1);
        make_random_map(4, 15);
        run_map(5, "filler after end group", 1'b0);
        make_random_map(5, 8);
        run_map(6, "restart after map_done", 1'b0);

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the DUT stopped making progress before all maps finished");
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: decompressor_top.sv
`timescale 1ns/1ps

module decompressor_top #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic                     layer23_gated_clk,
    input  logic                     rst_n,
    input  logic                     start,
    input  dec_pkg::compress_group_t mem_data,
    input  logic                     mem_data_valid,
    input  logic                     mem_ack,
    input  logic                     global_buffer_req,
    output logic                     mem_req,
    output dec_pkg::out_packet_t     out_packet,
    output logic                     map_done
);
    import dec_pkg::*;

    compress_group_t                      group_head;
    logic                                 fifo_empty;
    logic                                 pop;
    logic                                 advance;
    logic                                 last_group_drained;
    unit_residual_t [UNITS_PER_GROUP-1:0] unit_residual;   // loader to lanes
    unit_residual_t [UNITS_PER_GROUP-1:0] lane_residual;   // lanes back to loader
    lane_write_t    [UNITS_PER_GROUP-1:0] lane_write;
    logic           [UNITS_PER_GROUP:0][3:0] slot_chain;  // entry 0 is the packer fill level

    group_fetch_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_fetch (
        .layer23_gated_clk (layer23_gated_clk),
        .rst_n             (rst_n),
        .start             (start),
        .mem_data          (mem_data),
        .mem_data_valid    (mem_data_valid),
        .mem_ack           (mem_ack),
        .pop               (pop),
        .mem_req           (mem_req),
        .group_head        (group_head),
        .fifo_empty        (fifo_empty)
    );

    group_loader i_loader (
        .layer23_gated_clk  (layer23_gated_clk),
        .rst_n              (rst_n),
        .start              (start),
        .group_head         (group_head),
        .fifo_empty         (fifo_empty),
        .advance            (advance),
        .lane_residual      (lane_residual),
        .pop                (pop),
        .unit_residual      (unit_residual),
        .last_group_drained (last_group_drained)
    );

    // lanes hand the next free slot down the chain in unit order
    for (genvar i = 0; i < UNITS_PER_GROUP; i++) begin : g_lane
        unit_lane i_lane (
            .residual     (unit_residual[i]),
            .slot_in      (slot_chain[i]),
            .residual_out (lane_residual[i]),
            .slot_out     (slot_chain[i+1]),
            .lane_write   (lane_write[i])
        );
    end

    packet_packer i_packer (
        .layer23_gated_clk  (layer23_gated_clk),
        .rst_n              (rst_n),
        .start              (start),
        .global_buffer_req  (global_buffer_req),
        .lane_write         (lane_write),
        .slot_end           (slot_chain[UNITS_PER_GROUP]),
        .last_group_drained (last_group_drained),
        .advance            (advance),
        .fill_level         (slot_chain[0]),
        .out_packet         (out_packet),
        .map_done           (map_done)
    );

endmodule

// File: packet_packer.sv
`timescale 1ns/1ps

module packet_packer (
    input  logic                                           layer23_gated_clk,
    input  logic                                           rst_n,
    input  logic                                           start,
    input  logic                                           global_buffer_req,
    input  dec_pkg::lane_write_t [dec_pkg::UNITS_PER_GROUP-1:0] lane_write,
    input  logic [3:0]                                     slot_end,
    input  logic                                           last_group_drained,
    output logic                                           advance,
    output logic [3:0]                                     fill_level,
    output dec_pkg::out_packet_t                           out_packet,
    output logic                                           map_done
);
    import dec_pkg::*;

    logic        take;          // global buffer accepts the offered packet
    logic        pkt_full;
    logic        pkt_tail;      // map is over and a partial packet must go out
    logic [3:0]  fill_q;        // slots already used in the held packet
    out_packet_t pkt_next;

    assign take    = out_packet.packet_valid && global_buffer_req;
    assign advance = !out_packet.packet_valid || global_buffer_req;   // stall only while refused

    // after a take the lanes start over at slot 0 in the same cycle
    assign fill_level = take ? 4'd0 : fill_q;

    assign pkt_full = slot_end == 4'(PACKET_BYTES);
    assign pkt_tail = last_group_drained && (slot_end != 4'd0);

    always_comb begin
        if (take) begin
            pkt_next = '0;
        end else begin
            pkt_next = out_packet;
        end
        if (advance) begin
            // lanes never overlap, so a plain OR merges them
            for (int i = 0; i < UNITS_PER_GROUP; i++) begin
                pkt_next.data       = pkt_next.data | lane_write[i].data;
                pkt_next.valid_mask = pkt_next.valid_mask | lane_write[i].mask;
            end
            pkt_next.packet_valid = pkt_full || pkt_tail;
        end
    end

    always_ff @(posedge layer23_gated_clk or negedge rst_n) begin
        if (!rst_n) begin
            out_packet <= '0;
            fill_q     <= '0;
            map_done   <= 1'b0;
        end else if (start) begin
            out_packet <= '0;
            fill_q     <= '0;
            map_done   <= 1'b0;
        end else begin
            out_packet <= pkt_next;
            if (advance) begin
                fill_q <= slot_end;
            end
            // last group empty and no byte held, which also covers the cycle
            // the final packet is taken
            if (advance && last_group_drained && slot_end == 4'd0) begin
                map_done <= 1'b1;
            end
        end
    end

endmodule

// File: unit_lane.sv
`timescale 1ns/1ps

module unit_lane (
    input  dec_pkg::unit_residual_t residual,
    input  logic [3:0]              slot_in,
    output dec_pkg::unit_residual_t residual_out,
    output logic [3:0]              slot_out,
    output dec_pkg::lane_write_t    lane_write
);
    import dec_pkg::*;

    logic [4:0] slot_ext;       // first free slot, widened for the arithmetic
    logic [4:0] zeros_ext;
    logic [4:0] unit_len;       // bytes this unit still owes
    logic [4:0] free_slots;     // room left in the packet from slot_in on
    logic [4:0] wr_len;         // bytes actually written this cycle

    assign slot_ext   = {1'b0, slot_in};
    assign zeros_ext  = {1'b0, residual.zeros_left};
    assign unit_len   = zeros_ext + {4'b0000, residual.val_pending};
    assign free_slots = 5'(PACKET_BYTES) - slot_ext;
    assign wr_len     = (unit_len < free_slots) ? unit_len : free_slots;

    assign slot_out = slot_in + wr_len[3:0];   // next lane starts where this one stopped

    // zeros are used up first, the value only goes once every zero is out
    always_comb begin
        residual_out.val = residual.val;
        if (wr_len < zeros_ext) begin
            residual_out.zeros_left  = residual.zeros_left - wr_len[3:0];
            residual_out.val_pending = residual.val_pending;
        end else begin
            residual_out.zeros_left  = '0;
            residual_out.val_pending = residual.val_pending && (wr_len == zeros_ext);
        end
    end

    // place the bytes at their packet slots, zeros ahead of the value
    always_comb begin
        lane_write = '0;
        for (int k = 0; k < PACKET_BYTES; k++) begin
            if ((5'(k) >= slot_ext) && (5'(k) < slot_ext + wr_len)) begin
                lane_write.mask[k] = 1'b1;
                if (5'(k) - slot_ext < zeros_ext) begin
                    lane_write.data[k] = 8'h00;
                end else begin
                    lane_write.data[k] = residual.val;     // always the last byte written
                end
            end
        end
    end

endmodule

// File: group_loader.sv
`timescale 1ns/1ps

module group_loader (
    input  logic                                              layer23_gated_clk,
    input  logic                                              rst_n,
    input  logic                                              start,
    input  dec_pkg::compress_group_t                          group_head,
    input  logic                                              fifo_empty,
    input  logic                                              advance,
    input  dec_pkg::unit_residual_t [dec_pkg::UNITS_PER_GROUP-1:0] lane_residual,
    output logic                                              pop,
    output dec_pkg::unit_residual_t [dec_pkg::UNITS_PER_GROUP-1:0] unit_residual,
    output logic                                              last_group_drained
);
    import dec_pkg::*;

    loader_state_e                           state;
    logic                                    end_group;   // group in hand closes the map
    logic                                    head_is_end;
    logic                                    all_empty;   // lanes drain everything this cycle
    unit_residual_t [UNITS_PER_GROUP-1:0]    loaded;      // head group turned into residuals

    // units before the end index are whole, the end unit keeps its value only
    // with the end flag, anything later is padding
    function automatic unit_residual_t unit_to_residual(
        input compress_unit_t unit,
        input logic [2:0]     idx,
        input logic [2:0]     end_idx,
        input logic           end_flag
    );
        unit_residual_t res;
        res.val = unit.val;
        if (idx < end_idx) begin
            res.zeros_left  = unit.zero_run;               // all ones end index lands here too
            res.val_pending = 1'b1;
        end else if (idx == end_idx) begin
            res.zeros_left  = unit.zero_run;
            res.val_pending = end_flag;
        end else begin
            res.zeros_left  = '0;
            res.val_pending = 1'b0;
        end
        return res;
    endfunction

    assign head_is_end = group_head.end_idx != END_IDX_ALL;

    always_comb begin
        for (int i = 0; i < UNITS_PER_GROUP; i++) begin
            loaded[i] = unit_to_residual(group_head.units[i], 3'(i),
                                         group_head.end_idx, group_head.end_flag);
        end
    end

    always_comb begin
        all_empty = 1'b1;
        for (int i = 0; i < UNITS_PER_GROUP; i++) begin
            if (lane_residual[i].zeros_left != '0 || lane_residual[i].val_pending) begin
                all_empty = 1'b0;
            end
        end
    end

    // pop on the first load and whenever the group in hand empties out
    assign pop = advance && !fifo_empty &&
                 ((state == ST_LOAD) || (state == ST_EXPAND && all_empty && !end_group));

    assign last_group_drained = end_group && all_empty &&
                                (state == ST_EXPAND || state == ST_FINISHED);

    always_ff @(posedge layer23_gated_clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= ST_IDLE;
            unit_residual <= '0;
            end_group     <= 1'b0;
        end else if (start) begin
            state         <= ST_LOAD;
            unit_residual <= '0;
            end_group     <= 1'b0;
        end else if (advance) begin
            case (state)
                ST_LOAD: begin
                    if (!fifo_empty) begin
                        unit_residual <= loaded;
                        end_group     <= head_is_end;
                        state         <= ST_EXPAND;
                    end
                end
                ST_EXPAND: begin
                    if (all_empty && end_group) begin
                        unit_residual <= lane_residual;     // nothing left, hold until next start
                        state         <= ST_FINISHED;
                    end else if (all_empty && !fifo_empty) begin
                        unit_residual <= loaded;            // back to back groups, no bubble
                        end_group     <= head_is_end;
                    end else if (all_empty) begin
                        unit_residual <= lane_residual;
                        state         <= ST_LOAD;           // queue ran dry, wait for memory
                    end else begin
                        unit_residual <= lane_residual;     // partly written, keep the rest
                    end
                end
                default: begin
                end
            endcase
        end
    end

endmodule

// File: group_fetch_fifo.sv
`timescale 1ns/1ps

module group_fetch_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic                     layer23_gated_clk,
    input  logic                     rst_n,
    input  logic                     start,
    input  dec_pkg::compress_group_t mem_data,
    input  logic                     mem_data_valid,
    input  logic                     mem_ack,
    input  logic                     pop,
    output logic                     mem_req,
    output dec_pkg::compress_group_t group_head,
    output logic                     fifo_empty
);
    import dec_pkg::*;

    localparam int AW = $clog2(FIFO_DEPTH);

    compress_group_t fifo_mem [FIFO_DEPTH];
    logic [AW:0]     wr_ptr;        // next slot an arriving word lands in
    logic [AW:0]     rsv_ptr;       // slots already promised to the memory
    logic [AW:0]     rd_ptr;        // head of the queue seen by the loader
    logic            fetch_en;      // high from start until the end group is stored
    logic            rsv_full;
    logic            wr_en;
    logic            word_is_end;

    // every slot between rd_ptr and rsv_ptr is either filled or still in flight
    assign rsv_full = (rsv_ptr[AW] != rd_ptr[AW]) &&
                      (rsv_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    assign mem_req = fetch_en && !rsv_full;

    // once fetch_en drops, late words from the memory are simply ignored
    assign wr_en       = mem_data_valid && fetch_en;
    assign word_is_end = mem_data.end_idx != END_IDX_ALL;   // a partial group closes the map

    assign fifo_empty = rd_ptr == wr_ptr;
    assign group_head = fifo_mem[rd_ptr[AW-1:0]];

    always_ff @(posedge layer23_gated_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rsv_ptr  <= '0;
            rd_ptr   <= '0;
            fetch_en <= 1'b0;
        end else if (start) begin
            // a new map throws away whatever the queue still holds
            wr_ptr   <= '0;
            rsv_ptr  <= '0;
            rd_ptr   <= '0;
            fetch_en <= 1'b1;
        end else begin
            if (mem_req && mem_ack) begin
                rsv_ptr <= rsv_ptr + 1'b1;                  // the memory took the request
            end
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
                if (word_is_end) begin
                    fetch_en <= 1'b0;                       // no more requests for this map
                end
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // arriving groups are written at the slot wr_ptr points to
    always_ff @(posedge layer23_gated_clk) begin
        if (wr_en) begin
            fifo_mem[wr_ptr[AW-1:0]] <= mem_data;
        end
    end

endmodule

// File: dec_pkg.sv
package dec_pkg;

    // one compress group carries five units below the four info bits
    localparam int UNITS_PER_GROUP = 5;
    localparam int PACKET_BYTES    = 8;                 // byte slots in one global buffer packet

    // end index value meaning every unit in the group is valid
    localparam logic [2:0] END_IDX_ALL = 3'b111;

    // val sits above zero_run so that unit 0 lands on bits 11:0 of the word
    typedef struct packed {
        logic [7:0] val;
        logic [3:0] zero_run;                           // zeros emitted ahead of val
    } compress_unit_t;

    // matches the 64-bit memory word bit for bit
    typedef struct packed {
        logic                                       end_flag;   // bit 63, end unit keeps its value
        logic [2:0]                                 end_idx;    // bits 62:60
        compress_unit_t [UNITS_PER_GROUP-1:0]       units;      // unit 0 at the low end
    } compress_group_t;

    // what one unit still owes the output stream
    typedef struct packed {
        logic [3:0] zeros_left;
        logic       val_pending;
        logic [7:0] val;
    } unit_residual_t;

    // one lane's bytes for the current packet, placed at their final slots
    typedef struct packed {
        logic [PACKET_BYTES-1:0][7:0] data;
        logic [PACKET_BYTES-1:0]      mask;
    } lane_write_t;

    typedef struct packed {
        logic [PACKET_BYTES-1:0][7:0] data;
        logic [PACKET_BYTES-1:0]      valid_mask;       // slot i holds a byte of the stream
        logic                         packet_valid;     // offered to the global buffer
    } out_packet_t;

    // the loader alternates load and expand until the end group drains
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOAD,
        ST_EXPAND,
        ST_FINISHED
    } loader_state_e;

endpackage
